// ==== all.f ====
hdl/decode_pkg.sv
hdl/reg_fields_if.sv
hdl/opcode_decoder.sv
hdl/immediate_extractor.sv
hdl/register_extractor.sv
hdl/operation_classifier.sv
hdl/decode_stage.sv
testbench/tb_decode_stage.sv

// ==== hdl/decode_pkg.sv ====
package decode_pkg;

  // Fixed field widths of the instruction set
  localparam int INSN_W    = 32;
  localparam int ADDR_W    = 64;
  localparam int IMM_W     = 64;
  localparam int GPR_IDX_W = 5;
  localparam int COND_W    = 4;

  // Number of decodable opcodes, OP_ERR included
  localparam int OPCODE_COUNT = 22;
  localparam int OPCODE_W     = $clog2(OPCODE_COUNT);

  typedef logic [INSN_W-1:0]    insn_t;
  typedef logic [ADDR_W-1:0]    addr_t;
  typedef logic [IMM_W-1:0]     imm_t;
  typedef logic [GPR_IDX_W-1:0] gpr_idx_t;
  typedef logic [COND_W-1:0]    cond_t;

  localparam gpr_idx_t LINK_REG = gpr_idx_t'(30);
  localparam gpr_idx_t ZERO_REG = gpr_idx_t'(31);

  typedef enum logic [OPCODE_W-1:0] {
    OP_LDUR,
    OP_STUR,
    OP_MOVZ,
    OP_MOVK,
    OP_ADD,
    OP_SUB,
    OP_ADDS,
    OP_SUBS,
    OP_ORN,
    OP_ORR,
    OP_EOR,
    OP_ANDS,
    OP_B,
    OP_BL,
    OP_B_COND,
    OP_CBZ,
    OP_CBNZ,
    OP_BR,
    OP_BLR,
    OP_RET,
    OP_NOP,
    OP_ERR
  } opcode_t;

  typedef enum logic {
    FU_ALU,
    FU_LS
  } fu_t;

  typedef enum logic [3:0] {
    FU_OP_PLUS,
    FU_OP_MINUS,
    FU_OP_LDUR,
    FU_OP_STUR,
    FU_OP_ORN,
    FU_OP_OR,
    FU_OP_EOR,
    FU_OP_AND,
    FU_OP_MOV,
    FU_OP_PASS_A,
    FU_OP_PLUS_SIGNED,
    FU_OP_B_COND
  } fu_op_t;

  // STUR reads its data register through dst, hence the third status
  typedef enum logic [1:0] {
    REG_IS_UNUSED,
    REG_IS_USED,
    REG_IS_STUR
  } reg_status_t;

endpackage

// ==== hdl/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage (
  input  logic                    in_clk,
  input  logic                    in_rst,
  // From fetch
  input  logic                    fetch_valid,
  output logic                    fetch_ready,
  input  decode_pkg::insn_t       fetch_insn,
  input  decode_pkg::addr_t       fetch_pc,
  // To rename
  output logic                    issue_valid,
  input  logic                    issue_ready,
  output decode_pkg::addr_t       pc,
  output decode_pkg::imm_t        imm,
  output logic                    imm_signed,
  output logic                    use_imm,
  output decode_pkg::gpr_idx_t    src1,
  output decode_pkg::reg_status_t src1_status,
  output decode_pkg::gpr_idx_t    src2,
  output decode_pkg::reg_status_t src2_status,
  output decode_pkg::gpr_idx_t    dst,
  output decode_pkg::reg_status_t dst_status,
  output decode_pkg::fu_t         fu_id,
  output decode_pkg::fu_op_t      fu_op,
  output logic                    set_nzcv,
  output logic                    uses_nzcv,
  output decode_pkg::cond_t       cond,
  output logic                    mispredict
);

  logic                stage_full;
  decode_pkg::insn_t   insn_q;
  decode_pkg::addr_t   pc_q;
  logic                fetch_fire;
  decode_pkg::opcode_t opcode;

  reg_fields_if reg_bus ();

  // Accept when empty or when the held item leaves this cycle
  assign fetch_ready = !stage_full || issue_ready;
  assign fetch_fire  = fetch_valid && fetch_ready;

  always_ff @(posedge in_clk) begin
    if (in_rst) begin
      stage_full <= 1'b0;
    end else if (fetch_fire) begin
      stage_full <= 1'b1;
    end else if (issue_ready) begin
      stage_full <= 1'b0;
    end
  end

  always_ff @(posedge in_clk) begin
    if (fetch_fire) begin
      insn_q <= fetch_insn;
      pc_q   <= fetch_pc;
    end
  end

  assign issue_valid = stage_full;
  assign pc          = pc_q;

  opcode_decoder u_opcode_decoder (
    .insn   (insn_q),
    .opcode (opcode)
  );

  immediate_extractor u_immediate_extractor (
    .insn       (insn_q),
    .opcode     (opcode),
    .imm        (imm),
    .imm_signed (imm_signed)
  );

  register_extractor u_register_extractor (
    .insn   (insn_q),
    .opcode (opcode),
    .regs   (reg_bus.producer)
  );

  operation_classifier u_operation_classifier (
    .insn       (insn_q),
    .opcode     (opcode),
    .fu_id      (fu_id),
    .fu_op      (fu_op),
    .set_nzcv   (set_nzcv),
    .uses_nzcv  (uses_nzcv),
    .use_imm    (use_imm),
    .cond       (cond),
    .mispredict (mispredict)
  );

  // Register fields out to the rename side
  assign src1        = reg_bus.src1;
  assign src1_status = reg_bus.src1_status;
  assign src2        = reg_bus.src2;
  assign src2_status = reg_bus.src2_status;
  assign dst         = reg_bus.dst;
  assign dst_status  = reg_bus.dst_status;

endmodule

// ==== hdl/immediate_extractor.sv ====
`timescale 1ns/1ps

module immediate_extractor (
  input  decode_pkg::insn_t   insn,
  input  decode_pkg::opcode_t opcode,
  output decode_pkg::imm_t    imm,
  output logic                imm_signed
);

  localparam int W = decode_pkg::IMM_W;

  always_comb begin
    case (opcode)
      decode_pkg::OP_LDUR, decode_pkg::OP_STUR: begin
        imm        = {{(W-9){insn[20]}}, insn[20:12]};
        imm_signed = 1'b1;
      end
      decode_pkg::OP_ADD, decode_pkg::OP_SUB: begin
        imm        = {{(W-12){1'b0}}, insn[21:10]};
        imm_signed = 1'b0;
      end
      decode_pkg::OP_MOVZ, decode_pkg::OP_MOVK: begin
        imm        = {{(W-16){1'b0}}, insn[20:5]};
        imm_signed = 1'b0;
      end
      // Word offsets become byte offsets
      decode_pkg::OP_B, decode_pkg::OP_BL: begin
        imm        = {{(W-28){insn[25]}}, insn[25:0], 2'b00};
        imm_signed = 1'b1;
      end
      decode_pkg::OP_B_COND, decode_pkg::OP_CBZ, decode_pkg::OP_CBNZ: begin
        imm        = {{(W-21){insn[23]}}, insn[23:5], 2'b00};
        imm_signed = 1'b1;
      end
      default: begin
        imm        = '0;
        imm_signed = 1'b0;
      end
    endcase
  end

endmodule

// ==== hdl/opcode_decoder.sv ====
`timescale 1ns/1ps

module opcode_decoder (
  input  decode_pkg::insn_t   insn,
  output decode_pkg::opcode_t opcode
);

  always_comb begin
    casez (insn)
      // Unscaled 64-bit store and load
      32'b1111_1000_000?_????_????_00??_????_????: opcode = decode_pkg::OP_STUR;
      32'b1111_1000_010?_????_????_00??_????_????: opcode = decode_pkg::OP_LDUR;
      // Wide moves, 64-bit
      32'b1101_0010_1???_????_????_????_????_????: opcode = decode_pkg::OP_MOVZ;
      32'b1111_0010_1???_????_????_????_????_????: opcode = decode_pkg::OP_MOVK;
      // Add and subtract with 12-bit immediate
      32'b1001_0001_0???_????_????_????_????_????: opcode = decode_pkg::OP_ADD;
      32'b1101_0001_0???_????_????_????_????_????: opcode = decode_pkg::OP_SUB;
      // Register forms, shift type LSL only
      32'b1010_1011_000?_????_????_????_????_????: opcode = decode_pkg::OP_ADDS;
      32'b1110_1011_000?_????_????_????_????_????: opcode = decode_pkg::OP_SUBS;
      32'b1010_1010_001?_????_????_????_????_????: opcode = decode_pkg::OP_ORN;
      32'b1010_1010_000?_????_????_????_????_????: opcode = decode_pkg::OP_ORR;
      32'b1100_1010_000?_????_????_????_????_????: opcode = decode_pkg::OP_EOR;
      32'b1110_1010_000?_????_????_????_????_????: opcode = decode_pkg::OP_ANDS;
      // Immediate branches
      32'b0001_01??_????_????_????_????_????_????: opcode = decode_pkg::OP_B;
      32'b1001_01??_????_????_????_????_????_????: opcode = decode_pkg::OP_BL;
      32'b0101_0100_????_????_????_????_???0_????: opcode = decode_pkg::OP_B_COND;
      32'b1011_0100_????_????_????_????_????_????: opcode = decode_pkg::OP_CBZ;
      32'b1011_0101_????_????_????_????_????_????: opcode = decode_pkg::OP_CBNZ;
      // Register-indirect branches
      32'b1101_0110_0001_1111_0000_00??_???0_0000: opcode = decode_pkg::OP_BR;
      32'b1101_0110_0011_1111_0000_00??_???0_0000: opcode = decode_pkg::OP_BLR;
      32'b1101_0110_0101_1111_0000_00??_???0_0000: opcode = decode_pkg::OP_RET;
      // Hint space, exact NOP encoding
      32'b1101_0101_0000_0011_0010_0000_0001_1111: opcode = decode_pkg::OP_NOP;
      // HLT and everything unsupported end up here
      default:                                     opcode = decode_pkg::OP_ERR;
    endcase
  end

endmodule

// ==== hdl/operation_classifier.sv ====
`timescale 1ns/1ps

module operation_classifier (
  input  decode_pkg::insn_t   insn,
  input  decode_pkg::opcode_t opcode,
  output decode_pkg::fu_t     fu_id,
  output decode_pkg::fu_op_t  fu_op,
  output logic                set_nzcv,
  output logic                uses_nzcv,
  output logic                use_imm,
  output decode_pkg::cond_t   cond,
  output logic                mispredict
);

  // Unit operation
  always_comb begin
    case (opcode)
      decode_pkg::OP_ADD, decode_pkg::OP_ADDS: fu_op = decode_pkg::FU_OP_PLUS;
      decode_pkg::OP_SUB, decode_pkg::OP_SUBS: fu_op = decode_pkg::FU_OP_MINUS;
      decode_pkg::OP_ORN:                      fu_op = decode_pkg::FU_OP_ORN;
      decode_pkg::OP_ORR:                      fu_op = decode_pkg::FU_OP_OR;
      decode_pkg::OP_EOR:                      fu_op = decode_pkg::FU_OP_EOR;
      decode_pkg::OP_ANDS:                     fu_op = decode_pkg::FU_OP_AND;
      decode_pkg::OP_LDUR:                     fu_op = decode_pkg::FU_OP_LDUR;
      decode_pkg::OP_STUR:                     fu_op = decode_pkg::FU_OP_STUR;
      decode_pkg::OP_MOVZ, decode_pkg::OP_MOVK: fu_op = decode_pkg::FU_OP_MOV;
      // PC plus signed offset
      decode_pkg::OP_B:                        fu_op = decode_pkg::FU_OP_PLUS_SIGNED;
      decode_pkg::OP_B_COND:                   fu_op = decode_pkg::FU_OP_B_COND;
      default:                                 fu_op = decode_pkg::FU_OP_PASS_A;
    endcase
  end

  always_comb begin
    if (opcode == decode_pkg::OP_LDUR || opcode == decode_pkg::OP_STUR) begin
      fu_id = decode_pkg::FU_LS;
    end else begin
      fu_id = decode_pkg::FU_ALU;
    end
  end

  assign set_nzcv = (opcode == decode_pkg::OP_ADDS) || (opcode == decode_pkg::OP_SUBS) ||
                    (opcode == decode_pkg::OP_ANDS);

  assign uses_nzcv = (opcode == decode_pkg::OP_B_COND);

  always_comb begin
    case (opcode)
      decode_pkg::OP_LDUR, decode_pkg::OP_STUR, decode_pkg::OP_MOVZ, decode_pkg::OP_MOVK,
      decode_pkg::OP_ADD, decode_pkg::OP_SUB, decode_pkg::OP_B, decode_pkg::OP_B_COND,
      decode_pkg::OP_BL: use_imm = 1'b1;
      default:           use_imm = 1'b0;
    endcase
  end

  // Condition field sits in the low nibble of B.cond only
  assign cond = uses_nzcv ? insn[3:0] : '0;

  // Register targets are unknown to the predictor
  assign mispredict = (opcode == decode_pkg::OP_BR) || (opcode == decode_pkg::OP_BLR) ||
                      (opcode == decode_pkg::OP_RET);

endmodule

// ==== hdl/reg_fields_if.sv ====
`timescale 1ns/1ps

interface reg_fields_if;

  decode_pkg::gpr_idx_t    src1;
  decode_pkg::reg_status_t src1_status;
  decode_pkg::gpr_idx_t    src2;
  decode_pkg::reg_status_t src2_status;
  decode_pkg::gpr_idx_t    dst;
  decode_pkg::reg_status_t dst_status;

  modport producer (
    output src1, src1_status, src2, src2_status, dst, dst_status
  );

  modport consumer (
    input src1, src1_status, src2, src2_status, dst, dst_status
  );

endinterface

// ==== hdl/register_extractor.sv ====
`timescale 1ns/1ps

module register_extractor (
  input decode_pkg::insn_t   insn,
  input decode_pkg::opcode_t opcode,
  reg_fields_if.producer     regs
);

  // Destination
  always_comb begin
    case (opcode)
      decode_pkg::OP_B, decode_pkg::OP_BR, decode_pkg::OP_B_COND, decode_pkg::OP_CBZ,
      decode_pkg::OP_CBNZ, decode_pkg::OP_RET, decode_pkg::OP_NOP, decode_pkg::OP_ERR: begin
        regs.dst        = decode_pkg::ZERO_REG;
        regs.dst_status = decode_pkg::REG_IS_UNUSED;
      end
      decode_pkg::OP_STUR: begin
        regs.dst        = decode_pkg::ZERO_REG;
        regs.dst_status = decode_pkg::REG_IS_STUR;
      end
      decode_pkg::OP_BL, decode_pkg::OP_BLR: begin
        regs.dst        = decode_pkg::LINK_REG;
        regs.dst_status = decode_pkg::REG_IS_USED;
      end
      default: begin
        regs.dst        = insn[4:0];
        regs.dst_status = decode_pkg::REG_IS_USED;
      end
    endcase
  end

  // First source, Rn in most formats but Rt for compare-and-branch
  always_comb begin
    case (opcode)
      decode_pkg::OP_MOVZ, decode_pkg::OP_MOVK, decode_pkg::OP_B, decode_pkg::OP_B_COND,
      decode_pkg::OP_BL, decode_pkg::OP_NOP, decode_pkg::OP_ERR: begin
        regs.src1        = decode_pkg::ZERO_REG;
        regs.src1_status = decode_pkg::REG_IS_UNUSED;
      end
      decode_pkg::OP_CBZ, decode_pkg::OP_CBNZ: begin
        regs.src1        = insn[4:0];
        regs.src1_status = decode_pkg::REG_IS_USED;
      end
      default: begin
        regs.src1        = insn[9:5];
        regs.src1_status = decode_pkg::REG_IS_USED;
      end
    endcase
  end

  // Second source, store data or Rm
  always_comb begin
    case (opcode)
      decode_pkg::OP_STUR: begin
        regs.src2        = insn[4:0];
        regs.src2_status = decode_pkg::REG_IS_USED;
      end
      decode_pkg::OP_ADDS, decode_pkg::OP_SUBS, decode_pkg::OP_ORN,
      decode_pkg::OP_ORR, decode_pkg::OP_EOR, decode_pkg::OP_ANDS: begin
        regs.src2        = insn[20:16];
        regs.src2_status = decode_pkg::REG_IS_USED;
      end
      default: begin
        regs.src2        = decode_pkg::ZERO_REG;
        regs.src2_status = decode_pkg::REG_IS_UNUSED;
      end
    endcase
  end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps --top-module tb_decode_stage \
  -f all.f -o sim_decode_stage
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_decode_stage > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Test FAILED" "$LOG"; then
  exit 1
fi
exit 0

// ==== testbench/tb_decode_stage.sv ====
`timescale 1ns/1ps

module tb_decode_stage;

  localparam int RESET_CYCLES = 16;
  localparam int NUM_VECTORS  = 21;
  localparam int DRIVE_DELAY  = 1;

  localparam decode_pkg::reg_status_t UN = decode_pkg::REG_IS_UNUSED;
  localparam decode_pkg::reg_status_t US = decode_pkg::REG_IS_USED;
  localparam decode_pkg::reg_status_t ST = decode_pkg::REG_IS_STUR;

  // Flags are {fu_ls, imm_signed, use_imm, set_nzcv, uses_nzcv, mispredict}
  typedef struct packed {
    decode_pkg::insn_t       insn;
    decode_pkg::addr_t       pc;
    decode_pkg::fu_op_t      fu_op;
    decode_pkg::gpr_idx_t    src1;
    decode_pkg::reg_status_t src1_status;
    decode_pkg::gpr_idx_t    src2;
    decode_pkg::reg_status_t src2_status;
    decode_pkg::gpr_idx_t    dst;
    decode_pkg::reg_status_t dst_status;
    decode_pkg::imm_t        imm;
    logic [5:0]              flags;
    decode_pkg::cond_t       cond;
  } vector_t;

  logic                    in_clk;
  logic                    in_rst;
  logic                    fetch_valid;
  logic                    fetch_ready;
  decode_pkg::insn_t       fetch_insn;
  decode_pkg::addr_t       fetch_pc;
  logic                    issue_valid;
  logic                    issue_ready;
  decode_pkg::addr_t       pc;
  decode_pkg::imm_t        imm;
  logic                    imm_signed;
  logic                    use_imm;
  decode_pkg::gpr_idx_t    src1;
  decode_pkg::reg_status_t src1_status;
  decode_pkg::gpr_idx_t    src2;
  decode_pkg::reg_status_t src2_status;
  decode_pkg::gpr_idx_t    dst;
  decode_pkg::reg_status_t dst_status;
  decode_pkg::fu_t         fu_id;
  decode_pkg::fu_op_t      fu_op;
  logic                    set_nzcv;
  logic                    uses_nzcv;
  decode_pkg::cond_t       cond;
  logic                    mispredict;

  vector_t vectors[$];
  int      checked;
  int      errors;
  integer  seed;

  decode_stage DUT (
    .in_clk      (in_clk),
    .in_rst      (in_rst),
    .fetch_valid (fetch_valid),
    .fetch_ready (fetch_ready),
    .fetch_insn  (fetch_insn),
    .fetch_pc    (fetch_pc),
    .issue_valid (issue_valid),
    .issue_ready (issue_ready),
    .pc          (pc),
    .imm         (imm),
    .imm_signed  (imm_signed),
    .use_imm     (use_imm),
    .src1        (src1),
    .src1_status (src1_status),
    .src2        (src2),
    .src2_status (src2_status),
    .dst         (dst),
    .dst_status  (dst_status),
    .fu_id       (fu_id),
    .fu_op       (fu_op),
    .set_nzcv    (set_nzcv),
    .uses_nzcv   (uses_nzcv),
    .cond        (cond),
    .mispredict  (mispredict)
  );

  initial begin
    in_clk = 1'b0;
    forever #4 in_clk = ~in_clk;
  end

  // PCs step by one word from a fixed base
  task automatic add_vector(input decode_pkg::insn_t insn, input decode_pkg::fu_op_t fu_op,
                            input decode_pkg::gpr_idx_t s1, input decode_pkg::reg_status_t s1_st,
                            input decode_pkg::gpr_idx_t s2, input decode_pkg::reg_status_t s2_st,
                            input decode_pkg::gpr_idx_t d, input decode_pkg::reg_status_t d_st,
                            input decode_pkg::imm_t imm_exp, input logic [5:0] flags,
                            input decode_pkg::cond_t cond_exp);
    vector_t v;
    v.insn        = insn;
    v.pc          = 64'h0000_0000_0040_0000 + 64'(vectors.size()) * 64'd4;
    v.fu_op       = fu_op;
    v.src1        = s1;
    v.src1_status = s1_st;
    v.src2        = s2;
    v.src2_status = s2_st;
    v.dst         = d;
    v.dst_status  = d_st;
    v.imm         = imm_exp;
    v.flags       = flags;
    v.cond        = cond_exp;
    vectors.push_back(v);
  endtask

  task automatic build_vectors();
    // ALU with immediate and with register
    add_vector(32'h91004041, decode_pkg::FU_OP_PLUS, 5'd2, US, 5'd31, UN, 5'd1, US,
               64'h10, 6'b001000, 4'h0);
    add_vector(32'hD13FFC83, decode_pkg::FU_OP_MINUS, 5'd4, US, 5'd31, UN, 5'd3, US,
               64'hFFF, 6'b001000, 4'h0);
    add_vector(32'hAB0700C5, decode_pkg::FU_OP_PLUS, 5'd6, US, 5'd7, US, 5'd5, US,
               64'h0, 6'b000100, 4'h0);
    add_vector(32'hEB0A0128, decode_pkg::FU_OP_MINUS, 5'd9, US, 5'd10, US, 5'd8, US,
               64'h0, 6'b000100, 4'h0);
    add_vector(32'hAA2D018B, decode_pkg::FU_OP_ORN, 5'd12, US, 5'd13, US, 5'd11, US,
               64'h0, 6'b000000, 4'h0);
    add_vector(32'hAA1001EE, decode_pkg::FU_OP_OR, 5'd15, US, 5'd16, US, 5'd14, US,
               64'h0, 6'b000000, 4'h0);
    add_vector(32'hCA130251, decode_pkg::FU_OP_EOR, 5'd18, US, 5'd19, US, 5'd17, US,
               64'h0, 6'b000000, 4'h0);
    add_vector(32'hEA1602B4, decode_pkg::FU_OP_AND, 5'd21, US, 5'd22, US, 5'd20, US,
               64'h0, 6'b000100, 4'h0);
    // Load and store with offsets -8 and +16, then wide moves
    add_vector(32'hF85F8041, decode_pkg::FU_OP_LDUR, 5'd2, US, 5'd31, UN, 5'd1, US,
               64'hFFFF_FFFF_FFFF_FFF8, 6'b111000, 4'h0);
    add_vector(32'hF8010083, decode_pkg::FU_OP_STUR, 5'd4, US, 5'd3, US, 5'd31, ST,
               64'h10, 6'b111000, 4'h0);
    add_vector(32'hD297DDE5, decode_pkg::FU_OP_MOV, 5'd31, UN, 5'd31, UN, 5'd5, US,
               64'hBEEF, 6'b001000, 4'h0);
    add_vector(32'hF2A24686, decode_pkg::FU_OP_MOV, 5'd31, UN, 5'd31, UN, 5'd6, US,
               64'h1234, 6'b001000, 4'h0);
    // B -8, BL +0x100, B.NE -16, CBZ +32
    add_vector(32'h17FFFFFE, decode_pkg::FU_OP_PLUS_SIGNED, 5'd31, UN, 5'd31, UN, 5'd31, UN,
               64'hFFFF_FFFF_FFFF_FFF8, 6'b011000, 4'h0);
    add_vector(32'h94000040, decode_pkg::FU_OP_PASS_A, 5'd31, UN, 5'd31, UN, 5'd30, US,
               64'h100, 6'b011000, 4'h0);
    add_vector(32'h54FFFF81, decode_pkg::FU_OP_B_COND, 5'd31, UN, 5'd31, UN, 5'd31, UN,
               64'hFFFF_FFFF_FFFF_FFF0, 6'b011010, 4'h1);
    add_vector(32'hB4000107, decode_pkg::FU_OP_PASS_A, 5'd7, US, 5'd31, UN, 5'd31, UN,
               64'h20, 6'b010000, 4'h0);
    // Register-indirect branches
    add_vector(32'hD61F0120, decode_pkg::FU_OP_PASS_A, 5'd9, US, 5'd31, UN, 5'd31, UN,
               64'h0, 6'b000001, 4'h0);
    add_vector(32'hD63F0140, decode_pkg::FU_OP_PASS_A, 5'd10, US, 5'd31, UN, 5'd30, US,
               64'h0, 6'b000001, 4'h0);
    add_vector(32'hD65F03C0, decode_pkg::FU_OP_PASS_A, 5'd30, US, 5'd31, UN, 5'd31, UN,
               64'h0, 6'b000001, 4'h0);
    // NOP, then HLT #0 which falls to the error opcode
    add_vector(32'hD503201F, decode_pkg::FU_OP_PASS_A, 5'd31, UN, 5'd31, UN, 5'd31, UN,
               64'h0, 6'b000000, 4'h0);
    add_vector(32'hD4400000, decode_pkg::FU_OP_PASS_A, 5'd31, UN, 5'd31, UN, 5'd31, UN,
               64'h0, 6'b000000, 4'h0);
  endtask

  task automatic compare_value(input string name, input int idx,
                               input logic [63:0] got, input logic [63:0] expected);
    if (got !== expected) begin
      errors++;
      $display("Mismatch on %s for item %0d: got %0h, expected %0h", name, idx, got, expected);
    end
  endtask

  task automatic check_item(input int idx);
    vector_t         v;
    decode_pkg::fu_t exp_fu;
    v      = vectors[idx];
    exp_fu = v.flags[5] ? decode_pkg::FU_LS : decode_pkg::FU_ALU;
    compare_value("pc", idx, pc, v.pc);
    compare_value("fu_id", idx, 64'(fu_id), 64'(exp_fu));
    compare_value("fu_op", idx, 64'(fu_op), 64'(v.fu_op));
    compare_value("src1", idx, 64'(src1), 64'(v.src1));
    compare_value("src1_status", idx, 64'(src1_status), 64'(v.src1_status));
    compare_value("src2", idx, 64'(src2), 64'(v.src2));
    compare_value("src2_status", idx, 64'(src2_status), 64'(v.src2_status));
    compare_value("dst", idx, 64'(dst), 64'(v.dst));
    compare_value("dst_status", idx, 64'(dst_status), 64'(v.dst_status));
    compare_value("imm", idx, imm, v.imm);
    compare_value("imm_signed", idx, 64'(imm_signed), 64'(v.flags[4]));
    compare_value("use_imm", idx, 64'(use_imm), 64'(v.flags[3]));
    compare_value("set_nzcv", idx, 64'(set_nzcv), 64'(v.flags[2]));
    compare_value("uses_nzcv", idx, 64'(uses_nzcv), 64'(v.flags[1]));
    compare_value("mispredict", idx, 64'(mispredict), 64'(v.flags[0]));
    compare_value("cond", idx, 64'(cond), 64'(v.cond));
  endtask

  // Back-pressure from the rename side
  initial begin
    seed        = 76604;
    issue_ready = 1'b0;
    forever begin
      @(posedge in_clk);
      #DRIVE_DELAY;
      issue_ready = ($random(seed) & 3) != 0;
    end
  end

  // Issue transfers are sampled mid-cycle, where all inputs are settled
  initial begin
    checked = 0;
    forever begin
      @(negedge in_clk);
      if (!in_rst && issue_valid && issue_ready) begin
        if (checked < vectors.size()) begin
          check_item(checked);
        end else begin
          errors++;
          $display("Extra item left the stage with pc %0h", pc);
        end
        checked++;
      end
    end
  end

  initial begin
    repeat (RESET_CYCLES + NUM_VECTORS * 20) @(posedge in_clk);
    $display("Timeout: %0d of %0d items left the stage", checked, NUM_VECTORS);
    $display("Test FAILED");
    $finish;
  end

  initial begin
    int   i;
    logic accepted;
    errors      = 0;
    in_rst      = 1'b1;
    fetch_valid = 1'b0;
    fetch_insn  = '0;
    fetch_pc    = '0;
    build_vectors();
    if (vectors.size() != NUM_VECTORS) begin
      errors++;
      $display("Vector table holds %0d entries instead of %0d", vectors.size(), NUM_VECTORS);
    end
    repeat (RESET_CYCLES) @(posedge in_clk);
    #DRIVE_DELAY;
    in_rst = 1'b0;
    @(negedge in_clk);
    if (issue_valid !== 1'b0 || fetch_ready !== 1'b1) begin
      errors++;
      $display("After reset the stage is not empty and ready");
    end
    @(posedge in_clk);
    #DRIVE_DELAY;
    // Each word is held until the stage takes it
    for (i = 0; i < vectors.size(); i++) begin
      fetch_valid = 1'b1;
      fetch_insn  = vectors[i].insn;
      fetch_pc    = vectors[i].pc;
      accepted    = 1'b0;
      while (!accepted) begin
        @(negedge in_clk);
        accepted = fetch_ready;
        @(posedge in_clk);
        #DRIVE_DELAY;
      end
    end
    fetch_valid = 1'b0;
    fetch_insn  = '0;
    wait (checked >= vectors.size());
    repeat (8) @(posedge in_clk);
    @(negedge in_clk);
    if (issue_valid !== 1'b0) begin
      errors++;
      $display("Stage still holds an item after the last transfer");
    end
    $display("Checked %0d of %0d items with %0d errors", checked, NUM_VECTORS, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule
